/* hw/mem_pkg.sv */
// shared address map and request/response types; region decode uses the top 4 address bits only
`default_nettype none

package mem_pkg;

   // address map
   localparam int PADDR_WIDTH   = 32;
   localparam int REGION_WIDTH  = 4;
   localparam int IO_ADDR_WIDTH = PADDR_WIDTH - REGION_WIDTH;

   localparam logic [REGION_WIDTH-1:0] BRAM_REGION = 4'h8;
   localparam logic [REGION_WIDTH-1:0] IO_REGION   = 4'h4;

   // data paths
   localparam int MEM_DAT_WIDTH = 128;
   localparam int IO_DAT_WIDTH  = 32;
   localparam int STRB_WIDTH    = MEM_DAT_WIDTH / 8;
   localparam int IO_STRB_WIDTH = IO_DAT_WIDTH / 8;

   // 4 KB boot ram geometry
   localparam int BRAM_ADDR_WIDTH  = 12;
   localparam int BRAM_LINE_OFFSET = 4;
   localparam int BRAM_LINE_WIDTH  = BRAM_ADDR_WIDTH - BRAM_LINE_OFFSET;
   localparam int BRAM_LINES       = 2 ** BRAM_LINE_WIDTH;

   // io register window
   localparam int IO_WORDS       = 8;
   localparam int IO_WORD_WIDTH  = $clog2(IO_WORDS);
   localparam int IO_WORD_OFFSET = $clog2(IO_STRB_WIDTH);

   typedef enum logic [1:0] {
      TGT_NONE,
      TGT_BRAM,
      TGT_IO
   } target_e;

   typedef struct packed {
      logic                   valid;
      logic                   write;
      logic [PADDR_WIDTH-1:0] addr;
      logic [MEM_DAT_WIDTH-1:0] wdata;
      logic [STRB_WIDTH-1:0]  strb;
   } mem_req_t;

   typedef struct packed {
      logic                     valid;
      logic                     err;
      logic [MEM_DAT_WIDTH-1:0] rdata;
   } mem_rsp_t;

   typedef struct packed {
      logic                       en;
      logic [STRB_WIDTH-1:0]      we;
      logic [BRAM_LINE_WIDTH-1:0] line;
      logic [MEM_DAT_WIDTH-1:0]   wdata;
   } bram_req_t;

   typedef struct packed {
      logic                     en;
      logic [IO_STRB_WIDTH-1:0] we;
      logic [IO_WORD_WIDTH-1:0] word;
      logic [IO_DAT_WIDTH-1:0]  wdata;
   } io_req_t;

endpackage

`default_nettype wire

/* hw/mem_router.sv */
// request router; no back-pressure, responses come exactly two edges after the request edge
`timescale 1ns/1ps
`default_nettype none

module mem_router (
   input  logic                              mig_clk,
   input  logic                              rst_i,
   input  mem_pkg::mem_req_t                 req_i,
   output mem_pkg::bram_req_t                bram_req_o,
   input  logic [mem_pkg::MEM_DAT_WIDTH-1:0] bram_rdata_i,
   output mem_pkg::io_req_t                  io_req_o,
   input  logic [mem_pkg::IO_DAT_WIDTH-1:0]  io_rdata_i,
   output mem_pkg::mem_rsp_t                 rsp_o
);

   logic [mem_pkg::REGION_WIDTH-1:0]    region;
   logic [mem_pkg::IO_ADDR_WIDTH-1:0]   io_off;
   mem_pkg::target_e                    tgt_d;

   logic                                s1_valid;
   logic                                s1_write;
   mem_pkg::target_e                    s1_tgt;
   logic [mem_pkg::BRAM_LINE_WIDTH-1:0] s1_line;
   logic [mem_pkg::IO_WORD_WIDTH-1:0]   s1_word;
   logic [mem_pkg::MEM_DAT_WIDTH-1:0]   s1_wdata;
   logic [mem_pkg::STRB_WIDTH-1:0]      s1_strb;

   logic                                s2_valid;
   logic                                s2_write;
   mem_pkg::target_e                    s2_tgt;
   logic [mem_pkg::MEM_DAT_WIDTH-1:0]   rdata_d;

   // strip the region nibble
   assign region = req_i.addr[mem_pkg::PADDR_WIDTH-1 -: mem_pkg::REGION_WIDTH];
   assign io_off = req_i.addr[mem_pkg::IO_ADDR_WIDTH-1:0];

   always_comb begin
      if (region == mem_pkg::BRAM_REGION) begin
         tgt_d = mem_pkg::TGT_BRAM;
      end else if (region == mem_pkg::IO_REGION) begin
         tgt_d = mem_pkg::TGT_IO;
      end else begin
         tgt_d = mem_pkg::TGT_NONE;
      end
   end

   // stage 1 control
   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         s1_valid <= 1'b0;
         s1_write <= 1'b0;
         s1_tgt   <= mem_pkg::TGT_NONE;
      end else begin
         s1_valid <= req_i.valid;
         s1_write <= req_i.write;
         s1_tgt   <= tgt_d;
      end
   end

   // stage 1 payload
   always_ff @(posedge mig_clk) begin
      if (req_i.valid) begin
         s1_line  <= req_i.addr[mem_pkg::BRAM_ADDR_WIDTH-1:mem_pkg::BRAM_LINE_OFFSET];
         s1_word  <= io_off[mem_pkg::IO_WORD_OFFSET +: mem_pkg::IO_WORD_WIDTH];
         s1_wdata <= req_i.wdata;
         s1_strb  <= req_i.strb;
      end
   end

   // at most one target enabled, none for unmapped
   always_comb begin
      bram_req_o.en    = s1_valid && (s1_tgt == mem_pkg::TGT_BRAM);
      bram_req_o.we    = s1_write ? s1_strb : '0;
      bram_req_o.line  = s1_line;
      bram_req_o.wdata = s1_wdata;
      io_req_o.en      = s1_valid && (s1_tgt == mem_pkg::TGT_IO);
      io_req_o.we      = s1_write ? s1_strb[mem_pkg::IO_STRB_WIDTH-1:0] : '0;
      io_req_o.word    = s1_word;
      io_req_o.wdata   = s1_wdata[mem_pkg::IO_DAT_WIDTH-1:0];
   end

   // stage 2 waits for target data
   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         s2_valid <= 1'b0;
         s2_write <= 1'b0;
         s2_tgt   <= mem_pkg::TGT_NONE;
      end else begin
         s2_valid <= s1_valid;
         s2_write <= s1_write;
         s2_tgt   <= s1_tgt;
      end
   end

   // writes and errors return zero data
   always_comb begin
      rdata_d = '0;
      if (s2_valid && !s2_write) begin
         if (s2_tgt == mem_pkg::TGT_BRAM) begin
            rdata_d = bram_rdata_i;
         end else if (s2_tgt == mem_pkg::TGT_IO) begin
            rdata_d = {{(mem_pkg::MEM_DAT_WIDTH - mem_pkg::IO_DAT_WIDTH){1'b0}}, io_rdata_i};
         end
      end
   end

   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         rsp_o <= '0;
      end else begin
         rsp_o.valid <= s2_valid;
         rsp_o.err   <= s2_valid && (s2_tgt == mem_pkg::TGT_NONE);
         rsp_o.rdata <= rdata_d;
      end
   end

endmodule

`default_nettype wire

/* hw/boot_bram.sv */
// boot ram, 256 lines of 128 bits; contents undefined until written, read data valid one cycle after en
`timescale 1ns/1ps
`default_nettype none

module boot_bram (
   input  logic                              mig_clk,
   input  mem_pkg::bram_req_t                bram_req_i,
   output logic [mem_pkg::MEM_DAT_WIDTH-1:0] rdata_o
);

   logic [mem_pkg::MEM_DAT_WIDTH-1:0]   ram [mem_pkg::BRAM_LINES];
   logic [mem_pkg::BRAM_LINE_WIDTH-1:0] line_q;

   // byte lanes written independently
   always_ff @(posedge mig_clk) begin
      if (bram_req_i.en) begin
         line_q <= bram_req_i.line;
         for (int i = 0; i < mem_pkg::STRB_WIDTH; i++) begin
            if (bram_req_i.we[i]) begin
               ram[bram_req_i.line][i*8 +: 8] <= bram_req_i.wdata[i*8 +: 8];
            end
         end
      end
   end

   // read through the registered line index
   assign rdata_o = ram[line_q];

endmodule

`default_nettype wire

/* hw/io_window.sv */
// eight 32-bit registers cleared by reset; stands in for the peripheral space, no side effects on access
`timescale 1ns/1ps
`default_nettype none

module io_window (
   input  logic                             mig_clk,
   input  logic                             rst_i,
   input  mem_pkg::io_req_t                 io_req_i,
   output logic [mem_pkg::IO_DAT_WIDTH-1:0] rdata_o
);

   logic [mem_pkg::IO_DAT_WIDTH-1:0] regs [mem_pkg::IO_WORDS];
   logic [mem_pkg::IO_DAT_WIDTH-1:0] rdata_q;

   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         for (int w = 0; w < mem_pkg::IO_WORDS; w++) begin
            regs[w] <= '0;
         end
      end else if (io_req_i.en) begin
         for (int b = 0; b < mem_pkg::IO_STRB_WIDTH; b++) begin
            if (io_req_i.we[b]) begin
               regs[io_req_i.word][b*8 +: 8] <= io_req_i.wdata[b*8 +: 8];
            end
         end
      end
   end

   // capture on reads only
   always_ff @(posedge mig_clk) begin
      if (io_req_i.en && (io_req_i.we == '0)) begin
         rdata_q <= regs[io_req_i.word];
      end
   end

   assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* hw/mem_top.sv */
// on-chip memory side; single clock, host must accept every response as no back-pressure exists
`timescale 1ns/1ps
`default_nettype none

module mem_top (
   input  logic              mig_clk,
   input  logic              rst_i,
   input  mem_pkg::mem_req_t req_i,
   output mem_pkg::mem_rsp_t rsp_o
);

   mem_pkg::bram_req_t                bram_req;
   logic [mem_pkg::MEM_DAT_WIDTH-1:0] bram_rdata;
   mem_pkg::io_req_t                  io_req;
   logic [mem_pkg::IO_DAT_WIDTH-1:0]  io_rdata;

   mem_router u_router (
      .mig_clk      (mig_clk),
      .rst_i        (rst_i),
      .req_i        (req_i),
      .bram_req_o   (bram_req),
      .bram_rdata_i (bram_rdata),
      .io_req_o     (io_req),
      .io_rdata_i   (io_rdata),
      .rsp_o        (rsp_o)
   );

   boot_bram u_bram (
      .mig_clk    (mig_clk),
      .bram_req_i (bram_req),
      .rdata_o    (bram_rdata)
   );

   // region 0x4 peripheral stand-in
   io_window u_io (
      .mig_clk  (mig_clk),
      .rst_i    (rst_i),
      .io_req_i (io_req),
      .rdata_o  (io_rdata)
   );

endmodule

`default_nettype wire

/* verif/mem_chk.sv */
// router timing checks; request edge plus two more edges means rsp is seen three samples later
`timescale 1ns/1ps
`default_nettype none

module mem_chk (
   input logic              mig_clk,
   input logic              rst_i,
   input mem_pkg::mem_req_t req_i,
   input mem_pkg::mem_rsp_t rsp_i
);

   int fail_cnt = 0;

   a_req_to_rsp: assert property (@(posedge mig_clk) disable iff (rst_i)
      req_i.valid |-> ##3 rsp_i.valid)
      else begin
         $error("request not answered at the fixed latency");
         fail_cnt++;
      end

   a_rsp_from_req: assert property (@(posedge mig_clk) disable iff (rst_i)
      rsp_i.valid |-> $past(req_i.valid, 3))
      else begin
         $error("response without a matching request");
         fail_cnt++;
      end

   a_reset_quiet: assert property (@(posedge mig_clk) rst_i |=> !rsp_i.valid)
      else begin
         $error("response valid during reset");
         fail_cnt++;
      end

   a_err_needs_valid: assert property (@(posedge mig_clk) rsp_i.err |-> rsp_i.valid)
      else begin
         $error("err set without valid");
         fail_cnt++;
      end

endmodule

`default_nettype wire

/* verif/mem_monitor.sv */
// in-order response checker; expects one response per table line, samples on the falling edge
`timescale 1ns/1ps
`default_nettype none

module mem_monitor (
   input  logic              mig_clk,
   input  logic              rst_i,
   input  mem_pkg::mem_rsp_t rsp_i,
   input  int                num_tests_i,
   output int                mismatch_cnt_o,
   output int                rsp_cnt_o
);

   localparam int MAX_TESTS = 64;
   localparam int FIELDS    = 6;

   logic [mem_pkg::MEM_DAT_WIDTH-1:0] expected [MAX_TESTS*FIELDS];
   int                                mismatch_cnt = 0;
   int                                rsp_cnt      = 0;

   initial begin
      $readmemh("verif/mem_tests.hex", expected);
   end

   always @(negedge mig_clk) begin
      logic                              exp_err;
      logic [mem_pkg::MEM_DAT_WIDTH-1:0] exp_rdata;
      if (!rst_i && rsp_i.valid) begin
         if (rsp_cnt >= num_tests_i) begin
            $display("response %0d arrived with no request left to match it", rsp_cnt);
            mismatch_cnt++;
         end else begin
            exp_err   = expected[rsp_cnt*FIELDS+4][0];
            exp_rdata = expected[rsp_cnt*FIELDS+5];
            if (rsp_i.err !== exp_err) begin
               $display("** Error test %0d: rsp_o.err = %h, expected %h",
                        rsp_cnt, rsp_i.err, exp_err);
               mismatch_cnt++;
            end
            if (rsp_i.rdata !== exp_rdata) begin
               $display("** Error test %0d: rsp_o.rdata = %h, expected %h",
                        rsp_cnt, rsp_i.rdata, exp_rdata);
               mismatch_cnt++;
            end
         end
         rsp_cnt++;
      end
   end

   assign mismatch_cnt_o = mismatch_cnt;
   assign rsp_cnt_o      = rsp_cnt;

endmodule

`default_nettype wire

/* verif/tb_top.sv */
// needs verif/mem_tests.hex run from the project root; at most 64 tests, cmd bit 4 forces a zero gap
`timescale 1ns/1ps
`default_nettype none

module tb_top;

   localparam int MAX_TESTS    = 64;
   localparam int FIELDS       = 6;
   localparam int RESET_CYCLES = 10;
   localparam int MARGIN       = 40;

   logic              mig_clk;
   logic              rst_i;
   mem_pkg::mem_req_t req_i;
   mem_pkg::mem_rsp_t rsp_o;

   logic [mem_pkg::MEM_DAT_WIDTH-1:0] vec [MAX_TESTS*FIELDS];
   int                                num_tests;
   int                                mismatch_cnt;
   int                                rsp_cnt;
   logic [31:0]                       rnd_state;

   mem_top UUT (
      .mig_clk (mig_clk),
      .rst_i   (rst_i),
      .req_i   (req_i),
      .rsp_o   (rsp_o)
   );

   mem_monitor u_monitor (
      .mig_clk        (mig_clk),
      .rst_i          (rst_i),
      .rsp_i          (rsp_o),
      .num_tests_i    (num_tests),
      .mismatch_cnt_o (mismatch_cnt),
      .rsp_cnt_o      (rsp_cnt)
   );

   bind mem_router mem_chk u_chk (
      .mig_clk (mig_clk),
      .rst_i   (rst_i),
      .req_i   (req_i),
      .rsp_i   (rsp_o)
   );

   always #4 mig_clk = ~mig_clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic mem_pkg::mem_req_t request_from_vec(input int t);
      mem_pkg::mem_req_t r;
      r.valid = 1'b1;
      r.write = vec[t*FIELDS][0];
      r.addr  = vec[t*FIELDS+1][mem_pkg::PADDR_WIDTH-1:0];
      r.wdata = vec[t*FIELDS+2];
      r.strb  = vec[t*FIELDS+3][mem_pkg::STRB_WIDTH-1:0];
      return r;
   endfunction

   function automatic int missing_responses();
      return (rsp_cnt < num_tests) ? num_tests - rsp_cnt : 0;
   endfunction

   task automatic print_counts();
      $display("closing: %0d tests, %0d mismatches, %0d missing responses, %0d assertion failures",
               num_tests, mismatch_cnt, missing_responses(), UUT.u_router.u_chk.fail_cnt);
   endtask

   initial begin
      int gap;
      mig_clk   = 1'b0;
      rst_i     = 1'b1;
      req_i     = '0;
      rnd_state = 32'd41897;
      // all-ones cmd marks the end of the table
      for (int i = 0; i < MAX_TESTS*FIELDS; i++) begin
         vec[i] = '1;
      end
      $readmemh("verif/mem_tests.hex", vec);
      num_tests = 0;
      while (num_tests < MAX_TESTS && vec[num_tests*FIELDS] != '1) begin
         num_tests++;
      end
      repeat (RESET_CYCLES) @(posedge mig_clk);
      rst_i <= 1'b0;
      for (int t = 0; t < num_tests; t++) begin
         rnd_state = xorshift32(rnd_state);
         gap = vec[t*FIELDS][4] ? 0 : int'(rnd_state[1:0]);
         repeat (gap) begin
            @(posedge mig_clk);
            req_i <= '0;
         end
         @(posedge mig_clk);
         req_i <= request_from_vec(t);
      end
      @(posedge mig_clk);
      req_i <= '0;
      wait (rsp_cnt >= num_tests);
      // room for a stray extra response
      repeat (4) @(posedge mig_clk);
      print_counts();
      if (num_tests > 0 && mismatch_cnt == 0 && missing_responses() == 0 &&
          UUT.u_router.u_chk.fail_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // six cycles per test cover the worst gap plus latency
   initial begin
      #1;
      repeat (RESET_CYCLES + num_tests*6 + MARGIN) @(posedge mig_clk);
      $display("timeout: only %0d of %0d responses arrived in time", rsp_cnt, num_tests);
      print_counts();
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/mem_tests.hex */
// columns: cmd addr wdata strb exp_err exp_rdata, one request per line
// cmd bit 0 is write, cmd bit 4 issues the request with no idle gap before it
0 40000000 0 0 0 0
1 80000010 00112233445566778899aabbccddeeff ffff 0 0
0 80000010 0 0 0 00112233445566778899aabbccddeeff
1 80000010 ffffffffffffffffffffffffa5a5a5a5 000f 0 0
0 80000010 0 0 0 00112233445566778899aabba5a5a5a5
1 80000010 5a00000000000000000000000000003c 8001 0 0
0 8abcd010 0 0 0 5a112233445566778899aabba5a5a53c
1 40000008 deadbeef f 0 0
0 40000008 0 0 0 deadbeef
1 40000008 12345678 2 0 0
0 40000008 0 0 0 dead56ef
1 4000000c ffffffff00000000000000000000cafe ffff 0 0
0 4000000c 0 0 0 cafe
1 00000010 ffffffffffffffffffffffffffffffff ffff 1 0
1 20000008 ffffffff ffff 1 0
0 c0000008 0 0 1 0
0 80000010 0 0 0 5a112233445566778899aabba5a5a53c
0 40000008 0 0 0 dead56ef
1 80000020 0123456789abcdef0123456789abcdef ffff 0 0
10 80000020 0 0 0 0123456789abcdef0123456789abcdef
11 80000020 0 ff00 0 0
10 80000020 0 0 0 00000000000000000123456789abcdef
11 40000014 77 1 0 0
10 40000014 0 0 0 77
10 c0000000 0 0 1 0
10 8000001c 0 0 0 5a112233445566778899aabba5a5a53c
10 4000001c 0 0 0 0

/* sim.f */
hw/mem_pkg.sv
hw/mem_router.sv
hw/boot_bram.sv
hw/io_window.sv
hw/mem_top.sv
verif/mem_chk.sv
verif/mem_monitor.sv
verif/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_top
RTL_TOP   ?= mem_top
FILELIST  ?= sim.f
RTL_SRCS  ?= hw/mem_pkg.sv hw/mem_router.sv hw/boot_bram.sv hw/io_window.sv hw/mem_top.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
